// ==== list.f ====
+incdir+include
hdl/pad_pkg.sv
hdl/pad_cfg_regs.sv
hdl/pad_scanner.sv
hdl/mouse_tracker.sv
hdl/pad_port_top.sv
testbench/tb_pad_port_top.sv

// ==== testbench/tb_pad_port_top.sv ====
/*
 * Testbench of the controller port top level
 *  - clock, reset and cycle limit
 *  - Wishbone transfer task and value checker
 *  - stimulus table with expected nibbles, applied in a loop
 */

`include "pad_macros.svh"

module tb_pad_port_top
	import pad_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int OP_WRITE  = 0;
	localparam int OP_READ   = 1;
	localparam int OP_PAD    = 2;
	localparam int OP_PACKET = 3;
	localparam int HOLD      = 3;
	localparam logic [31:0] SEED = 32'h3ae7b427;

	logic         clk_sys;
	logic         reset;
	logic         wb_cyc;
	logic         wb_stb;
	logic         wb_we;
	wb_adr_t      wb_adr;
	wb_dat_t      wb_dat_w;
	wb_dat_t      wb_dat_r;
	logic         wb_ack;
	joy_t         joy_0;
	joy_t         joy_1;
	joy_t         joy_2;
	joy_t         joy_3;
	joy_t         joy_4;
	logic         mouse_stb;
	mouse_delta_t mouse_dx;
	mouse_delta_t mouse_dy;
	logic [1:0]   mouse_btn;
	logic         pad_sel;
	logic         pad_clr;
	nibble_t      pad_data;

	// Stimulus table, one entry per row in each queue
	int          row_op [$];
	logic [31:0] row_arg [$];
	int          row_hold [$];
	logic [7:0]  row_exp [$];

	joy_t        joy_val [`PAD_PLAYERS];
	logic [31:0] rng;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          cycle_limit = 1000000;

	pad_port_top u_pad_port_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Run timed out after %0d cycles before the table was finished", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Console view of a standard or six-button pad
	function automatic nibble_t expect_nibble(input joy_t j, input logic ph, input logic sel);
		nibble_t active;
		if (!ph && !sel)
			active = {j[7], j[6], j[5], j[4]};
		else if (!ph)
			active = {j[1], j[2], j[0], j[3]};
		else if (!sel)
			active = {j[11], j[10], j[9], j[8]};
		else
			active = 4'b1111;
		return ~active;
	endfunction

	function automatic nibble_t button_nibble(input logic [1:0] btn);
		return ~{2'b00, btn[0], btn[1]};
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic add_row(input int op, input logic [31:0] arg, input int hold,
			input logic [7:0] exp);
		row_op.push_back(op);
		row_arg.push_back(arg);
		row_hold.push_back(hold);
		row_exp.push_back(exp);
	endtask

	task automatic add_write(input wb_adr_t adr, input wb_dat_t data);
		add_row(OP_WRITE, {22'd0, adr, data}, 0, 8'h00);
	endtask

	task automatic add_read(input wb_adr_t adr, input wb_dat_t exp);
		add_row(OP_READ, {22'd0, adr, 8'h00}, 0, exp);
	endtask

	task automatic add_pad(input logic sel, input logic clr, input int hold, input nibble_t exp);
		add_row(OP_PAD, {30'd0, clr, sel}, hold, {4'h0, exp});
	endtask

	////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////

	task automatic build_table();
		logic [7:0] dx;
		logic [7:0] dy;
		logic [7:0] nx;
		logic [1:0] btn;
		nibble_t    move_nib [4];
		nibble_t    exp_nib;
		int         p;
		rng = SEED;
		for (p = 0; p < `PAD_PLAYERS; p++) begin
			rng = xorshift32(rng);
			joy_val[p] = rng[11:0];
		end
		rng = xorshift32(rng);
		dx  = rng[7:0];
		dy  = rng[15:8];
		// Exactly one button held to tell left from right
		btn = {!rng[16], rng[16]};
		nx  = 8'd0 - dx;
		move_nib[0] = nx[7:4];
		move_nib[1] = nx[3:0];
		move_nib[2] = dy[7:4];
		move_nib[3] = dy[3:0];

		// Reset values and register access
		add_pad(1'b0, 1'b0, 0, 4'h0);
		add_read(`PAD_REG_CTRL, 8'h00);
		add_read(`PAD_REG_STATUS, 8'h00);
		add_write(`PAD_REG_CTRL, 8'hFF);
		add_read(`PAD_REG_CTRL, 8'h07);
		add_write(`PAD_REG_CTRL, 8'h00);
		add_read(`PAD_REG_CTRL, 8'h00);
		add_write(2'd2, 8'h5A);
		add_read(2'd2, 8'h00);
		add_read(2'd3, 8'h00);
		add_read(`PAD_REG_CTRL, 8'h00);

		// Plain pad on port 0
		add_pad(1'b0, 1'b1, HOLD, 4'h0);
		add_pad(1'b0, 1'b0, HOLD, expect_nibble(joy_val[0], 1'b0, 1'b0));
		add_pad(1'b1, 1'b0, HOLD, expect_nibble(joy_val[0], 1'b0, 1'b1));
		add_pad(1'b0, 1'b0, HOLD, expect_nibble(joy_val[0], 1'b0, 1'b0));
		add_pad(1'b1, 1'b0, HOLD, expect_nibble(joy_val[0], 1'b0, 1'b1));
		add_read(`PAD_REG_STATUS, 8'h00);

		// Multitap scan, empty ports above the last player
		add_write(`PAD_REG_CTRL, 8'h01);
		add_pad(1'b0, 1'b1, HOLD, 4'h0);
		add_pad(1'b0, 1'b0, HOLD, expect_nibble(joy_val[0], 1'b0, 1'b0));
		for (p = 1; p < 8; p++) begin
			exp_nib = (p < `PAD_PLAYERS) ? expect_nibble(joy_val[p], 1'b0, 1'b1) : 4'hF;
			add_pad(1'b1, 1'b0, HOLD, exp_nib);
			add_read(`PAD_REG_STATUS, p[7:0]);
			exp_nib = (p < `PAD_PLAYERS) ? expect_nibble(joy_val[p], 1'b0, 1'b0) : 4'hF;
			add_pad(1'b0, 1'b0, HOLD, exp_nib);
		end
		// Saturates at port 7
		add_pad(1'b1, 1'b0, HOLD, 4'hF);
		add_read(`PAD_REG_STATUS, 8'h07);
		add_pad(1'b0, 1'b1, HOLD, 4'h0);
		add_pad(1'b0, 1'b0, HOLD, expect_nibble(joy_val[0], 1'b0, 1'b0));
		add_read(`PAD_REG_STATUS, 8'h00);

		// Six-button phase on the first two tap ports
		add_write(`PAD_REG_CTRL, 8'h03);
		add_pad(1'b0, 1'b1, HOLD, 4'h0);
		add_read(`PAD_REG_STATUS, 8'h08);
		add_pad(1'b0, 1'b0, HOLD, expect_nibble(joy_val[0], 1'b1, 1'b0));
		add_pad(1'b1, 1'b0, HOLD, expect_nibble(joy_val[1], 1'b1, 1'b1));
		add_read(`PAD_REG_STATUS, 8'h09);
		add_pad(1'b0, 1'b0, HOLD, expect_nibble(joy_val[1], 1'b1, 1'b0));
		add_pad(1'b0, 1'b1, HOLD, 4'h0);
		add_read(`PAD_REG_STATUS, 8'h00);
		add_pad(1'b0, 1'b0, HOLD, expect_nibble(joy_val[0], 1'b0, 1'b0));
		add_write(`PAD_REG_CTRL, 8'h00);
		add_pad(1'b0, 1'b1, HOLD, 4'h0);
		add_read(`PAD_REG_STATUS, 8'h00);
		add_pad(1'b0, 1'b0, HOLD, expect_nibble(joy_val[0], 1'b0, 1'b0));
		add_pad(1'b0, 1'b1, HOLD, 4'h0);
		add_read(`PAD_REG_STATUS, 8'h00);
		add_pad(1'b0, 1'b0, HOLD, expect_nibble(joy_val[0], 1'b0, 1'b0));

		// Mouse, idle timeout brings the count back to 3
		add_write(`PAD_REG_CTRL, 8'h04);
		add_pad(1'b0, 1'b1, HOLD, 4'h0);
		add_pad(1'b0, 1'b0, HOLD, button_nibble(2'b00));
		add_row(OP_PACKET, {14'd0, btn, dy, dx}, 1, 8'h00);
		add_pad(1'b0, 1'b0, `PAD_MOUSE_TIMEOUT + 16, button_nibble(btn));
		for (p = 0; p < 4; p++) begin
			add_pad(1'b0, 1'b1, HOLD, 4'h0);
			add_pad(1'b1, 1'b0, HOLD, move_nib[p]);
			add_pad(1'b0, 1'b0, HOLD, button_nibble(btn));
		end
		add_write(`PAD_REG_CTRL, 8'h00);
	endtask

	////////////////////////////////////////
	// Bus and row execution
	////////////////////////////////////////

	task automatic bus_transfer(input logic we, input wb_adr_t adr, input wb_dat_t wdata,
			output wb_dat_t rdata);
		int waited;
		check_value(wb_ack, 1'b0, "wb_ack low before a transfer");
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		@(posedge clk_sys);
		#1;
		waited = 1;
		while (!wb_ack && waited < 16) begin
			@(posedge clk_sys);
			#1;
			waited++;
		end
		if (!wb_ack) begin
			errors++;
			$display("Register block gave no acknowledge within 16 cycles at %0t ns", $time);
		end else begin
			check_value(waited, 1, "acknowledge one cycle after the request");
		end
		rdata  = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(posedge clk_sys);
		#1;
		check_value(wb_ack, 1'b0, "wb_ack high for a single cycle");
	endtask

	task automatic run_row(input int i);
		logic [31:0] arg;
		wb_dat_t     rdata;
		arg = row_arg[i];
		case (row_op[i])
			OP_WRITE: begin
				bus_transfer(1'b1, arg[9:8], arg[7:0], rdata);
			end
			OP_READ: begin
				bus_transfer(1'b0, arg[9:8], 8'h00, rdata);
				check_value(rdata, row_exp[i], $sformatf("row %0d read of address %0d", i,
					arg[9:8]));
			end
			OP_PAD: begin
				pad_sel = arg[0];
				pad_clr = arg[1];
				repeat (row_hold[i]) begin
					@(posedge clk_sys);
					#1;
				end
				check_value(pad_data, row_exp[i], $sformatf("row %0d pad_data, sel %0b clr %0b",
					i, arg[0], arg[1]));
			end
			default: begin
				// Strobe is a toggle, new deltas go with it
				mouse_dx  = arg[7:0];
				mouse_dy  = arg[15:8];
				mouse_btn = arg[17:16];
				mouse_stb = !mouse_stb;
				@(posedge clk_sys);
				#1;
			end
		endcase
	endtask

	initial begin
		build_table();
		cycle_limit = 2 * row_op.size() * 8 + `PAD_MOUSE_TIMEOUT + 500;
		reset     = 1'b1;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_dat_w  = '0;
		joy_0     = joy_val[0];
		joy_1     = joy_val[1];
		joy_2     = joy_val[2];
		joy_3     = joy_val[3];
		joy_4     = joy_val[4];
		mouse_stb = 1'b0;
		mouse_dx  = '0;
		mouse_dy  = '0;
		mouse_btn = 2'b00;
		pad_sel   = 1'b0;
		pad_clr   = 1'b0;
		repeat (5) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		for (int i = 0; i < row_op.size(); i++) begin
			run_row(i);
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== hdl/pad_port_top.sv ====
/*
 * Controller port top level
 *  - register block on Wishbone
 *  - console scanner
 *  - mouse tracker
 */

module pad_port_top
	import pad_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         wb_cyc,
	input  logic         wb_stb,
	input  logic         wb_we,
	input  wb_adr_t      wb_adr,
	input  wb_dat_t      wb_dat_w,
	output wb_dat_t      wb_dat_r,
	output logic         wb_ack,
	input  joy_t         joy_0,
	input  joy_t         joy_1,
	input  joy_t         joy_2,
	input  joy_t         joy_3,
	input  joy_t         joy_4,
	input  logic         mouse_stb,
	input  mouse_delta_t mouse_dx,
	input  mouse_delta_t mouse_dy,
	input  logic [1:0]   mouse_btn,
	input  logic         pad_sel,
	input  logic         pad_clr,
	output nibble_t      pad_data
);

	logic      tap_en;
	logic      six_en;
	logic      mouse_en;
	port_idx_t port_idx;
	logic      phase;
	wb_dat_t   mouse_byte;

	pad_cfg_regs u_pad_cfg_regs (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.port_idx (port_idx),
		.phase    (phase),
		.tap_en   (tap_en),
		.six_en   (six_en),
		.mouse_en (mouse_en)
	);

	pad_scanner u_pad_scanner (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pad_sel    (pad_sel),
		.pad_clr    (pad_clr),
		.tap_en     (tap_en),
		.six_en     (six_en),
		.mouse_en   (mouse_en),
		.joy_0      (joy_0),
		.joy_1      (joy_1),
		.joy_2      (joy_2),
		.joy_3      (joy_3),
		.joy_4      (joy_4),
		.mouse_byte (mouse_byte),
		.pad_data   (pad_data),
		.port_idx   (port_idx),
		.phase      (phase)
	);

	mouse_tracker u_mouse_tracker (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pad_clr    (pad_clr),
		.mouse_en   (mouse_en),
		.mouse_stb  (mouse_stb),
		.mouse_dx   (mouse_dx),
		.mouse_dy   (mouse_dy),
		.mouse_btn  (mouse_btn),
		.mouse_byte (mouse_byte)
	);

endmodule

// ==== hdl/mouse_tracker.sv ====
/*
 * Mouse side of the controller port
 *  - packet capture on strobe toggle
 *  - nibble counter on CLR rising edges with idle timeout
 *  - mouse byte assembly for the scanner
 */

`include "pad_macros.svh"

module mouse_tracker
	import pad_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         pad_clr,
	input  logic         mouse_en,
	input  logic         mouse_stb,
	input  mouse_delta_t mouse_dx,
	input  mouse_delta_t mouse_dy,
	input  logic [1:0]   mouse_btn,
	output wb_dat_t      mouse_byte
);

	localparam int unsigned TIMEOUT = `PAD_MOUSE_TIMEOUT;
	localparam int IDLE_W = $clog2(TIMEOUT + 1);

	logic              stb_q;
	logic              clr_q;
	logic [IDLE_W-1:0] idle_cnt;
	logic [1:0]        cnt;
	mouse_delta_t      pend_x;
	mouse_delta_t      pend_y;
	mouse_delta_t      rep_x;
	mouse_delta_t      rep_y;
	nibble_t           move_nib;

	always_ff @(posedge clk_sys) begin
		if (reset || !mouse_en) begin
			stb_q    <= mouse_stb;
			clr_q    <= 1'b0;
			idle_cnt <= '0;
			cnt      <= 2'd3;
			pend_x   <= '0;
			pend_y   <= '0;
			rep_x    <= '0;
			rep_y    <= '0;
		end else begin
			stb_q <= mouse_stb;
			clr_q <= pad_clr;

			// Idle timer runs only while CLR is low
			if (pad_clr) begin
				idle_cnt <= '0;
			end else if (idle_cnt != IDLE_W'(TIMEOUT)) begin
				idle_cnt <= idle_cnt + 1'b1;
			end
			if (idle_cnt == IDLE_W'(TIMEOUT)) begin
				cnt <= 2'd3;
			end

			// New packet, X axis runs the other way on the console
			if (stb_q != mouse_stb) begin
				pend_x <= -mouse_dx;
				pend_y <= mouse_dy;
			end

			if (pad_clr && !clr_q) begin
				cnt <= cnt + 2'd1;
				if (cnt == 2'd3) begin
					rep_x  <= pend_x;
					rep_y  <= pend_y;
					pend_x <= '0;
					pend_y <= '0;
				end
			end
		end
	end

	always_comb begin
		case (cnt)
			2'd0:    move_nib = rep_x[7:4];
			2'd1:    move_nib = rep_x[3:0];
			2'd2:    move_nib = rep_y[7:4];
			default: move_nib = rep_y[3:0];
		endcase
	end

	// Buttons are active low on the port
	assign mouse_byte = {move_nib, 2'b11, ~mouse_btn[0], ~mouse_btn[1]};

endmodule

// ==== hdl/pad_scanner.sv ====
/*
 * Console side of the controller port
 *  - SEL/CLR edge detection
 *  - multitap port counter and six-button phase
 *  - joystick to port word mapping, mouse on port 0
 *  - registered data nibble read by the console
 */

`include "pad_macros.svh"

module pad_scanner
	import pad_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      pad_sel,
	input  logic      pad_clr,
	input  logic      tap_en,
	input  logic      six_en,
	input  logic      mouse_en,
	input  joy_t      joy_0,
	input  joy_t      joy_1,
	input  joy_t      joy_2,
	input  joy_t      joy_3,
	input  joy_t      joy_4,
	input  wb_dat_t   mouse_byte,
	output nibble_t   pad_data,
	output port_idx_t port_idx,
	output logic      phase
);

	localparam int PLAYERS = `PAD_PLAYERS;

	joy_t       joy_arr [PLAYERS];
	port_word_t cur_word;
	nibble_t    cur_nibble;
	logic       sel_q;
	logic       clr_q;
	logic       sel_rise;
	logic       clr_rise;

	////////////////////////////////////////
	// Port word mapping
	////////////////////////////////////////

	// Nibble 0 standard buttons, 1 d-pad, 2 extra buttons, 3 reads 0000
	function automatic port_word_t map_joy(input joy_t j);
		nibble_t std_btn;
		nibble_t dpad;
		nibble_t ext_btn;
		std_btn = j[7:4];
		dpad    = {j[1], j[2], j[0], j[3]};
		ext_btn = j[11:8];
		return ~{4'hF, ext_btn, dpad, std_btn};
	endfunction

	assign joy_arr[0] = joy_0;
	assign joy_arr[1] = joy_1;
	assign joy_arr[2] = joy_2;
	assign joy_arr[3] = joy_3;
	assign joy_arr[4] = joy_4;

	always_comb begin
		if (port_idx == '0 && mouse_en) begin
			// Mouse byte sits in both halves of the word
			cur_word = {mouse_byte, mouse_byte};
		end else if (int'(port_idx) < PLAYERS) begin
			cur_word = map_joy(joy_arr[port_idx]);
		end else begin
			// Nothing plugged into the tap here
			cur_word = '1;
		end
	end

	assign cur_nibble = cur_word[{phase, pad_sel, 2'b00} +: 4];

	////////////////////////////////////////
	// SEL/CLR sequencing
	////////////////////////////////////////

	assign sel_rise = pad_sel && !sel_q;
	assign clr_rise = pad_clr && !clr_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel_q    <= 1'b0;
			clr_q    <= 1'b0;
			port_idx <= '0;
			phase    <= 1'b0;
			pad_data <= '0;
		end else begin
			sel_q <= pad_sel;
			clr_q <= pad_clr;
			if (pad_clr) begin
				port_idx <= '0;
				pad_data <= '0;
				// Six-button pads flip phase on every CLR pulse
				if (clr_rise) begin
					phase <= six_en ? !phase : 1'b0;
				end
			end else if (sel_rise && tap_en) begin
				if (port_idx != 3'd7) begin
					port_idx <= port_idx + 3'd1;
				end
			end else begin
				pad_data <= cur_nibble;
			end
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	a_clr_blanks_data: assert property (
		@(posedge clk_sys) disable iff (reset)
		pad_clr |=> pad_data == '0
	);

	// Without the tap the scan never leaves port 0
	a_no_tap_no_scan: assert property (
		@(posedge clk_sys) disable iff (reset)
		!tap_en && port_idx == '0 |=> port_idx == '0
	);

endmodule

// ==== hdl/pad_cfg_regs.sv ====
/*
 * Wishbone classic register block
 *  - control register with tap, six-button and mouse mode bits
 *  - read-only scan status (phase and tap port)
 *  - single-cycle acknowledge, unused addresses read 0
 */

`include "pad_macros.svh"

module pad_cfg_regs
	import pad_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      wb_cyc,
	input  logic      wb_stb,
	input  logic      wb_we,
	input  wb_adr_t   wb_adr,
	input  wb_dat_t   wb_dat_w,
	output wb_dat_t   wb_dat_r,
	output logic      wb_ack,
	input  port_idx_t port_idx,
	input  logic      phase,
	output logic      tap_en,
	output logic      six_en,
	output logic      mouse_en
);

	logic [2:0] mode_q;
	logic       xfer;
	wb_dat_t    rd_mux;

	// New request seen, ack not yet given
	assign xfer = wb_cyc && wb_stb && !wb_ack;

	always_comb begin
		case (wb_adr)
			`PAD_REG_CTRL:   rd_mux = {5'd0, mode_q};
			`PAD_REG_STATUS: rd_mux = {4'd0, phase, port_idx};
			default:         rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wb_ack <= 1'b0;
			mode_q <= '0;
		end else begin
			wb_ack <= xfer;
			if (xfer && wb_we && wb_adr == `PAD_REG_CTRL) begin
				mode_q <= wb_dat_w[2:0];
			end
		end
	end

	// Read data latched on the ack edge
	always_ff @(posedge clk_sys) begin
		if (xfer) begin
			wb_dat_r <= rd_mux;
		end
	end

	assign tap_en   = mode_q[`PAD_CTRL_TAP];
	assign six_en   = mode_q[`PAD_CTRL_SIX];
	assign mouse_en = mode_q[`PAD_CTRL_MOUSE];

	// Ack only ever answers a request from the previous cycle
	a_ack_needs_req: assert property (
		@(posedge clk_sys) disable iff (reset)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb)
	);

endmodule

// ==== hdl/pad_pkg.sv ====
/*
 * Shared types of the controller port
 *  - raw joystick word and active-low port word
 *  - console nibble and tap port index
 *  - Wishbone address and data fields
 *  - mouse movement delta
 */

package pad_pkg;

	////////////////////////////////////////
	// Joystick side
	////////////////////////////////////////

	// Active high
	// 0 right, 1 left, 2 down, 3 up
	// 4 I, 5 II, 6 select, 7 run
	// 8..11 buttons III to VI
	typedef logic [11:0] joy_t;

	// Active low, four nibbles picked by {phase, sel}
	typedef logic [15:0] port_word_t;

	// What the console sees on its data lines
	typedef logic [3:0] nibble_t;

	// Multitap port number, 5..7 are empty
	typedef logic [2:0] port_idx_t;

	////////////////////////////////////////
	// Register bus
	////////////////////////////////////////

	typedef logic [1:0] wb_adr_t;
	typedef logic [7:0] wb_dat_t;

	////////////////////////////////////////
	// Mouse
	////////////////////////////////////////

	// Signed movement per packet
	typedef logic signed [7:0] mouse_delta_t;

endpackage

// ==== include/pad_macros.svh ====
/*
 * Controller port constants
 *  - number of joystick inputs
 *  - register map of the Wishbone register block
 *  - bit positions in the control register
 *  - mouse idle timeout in clock cycles
 */

`ifndef PAD_MACROS_SVH
`define PAD_MACROS_SVH

////////////////////////////////////////
// Players
////////////////////////////////////////

// Joystick inputs, ports above this read as empty
`define PAD_PLAYERS 5

////////////////////////////////////////
// Register map
////////////////////////////////////////

`define PAD_REG_CTRL   2'd0
`define PAD_REG_STATUS 2'd1

// Control register bits
`define PAD_CTRL_TAP   0
`define PAD_CTRL_SIX   1
`define PAD_CTRL_MOUSE 2

// Cycles with CLR low before the mouse sequence restarts
`define PAD_MOUSE_TIMEOUT 4095

`endif
